// File: fx_pkg.sv
package fx_pkg;

    // signed fixed point, 1 sign, 5 integer and 5 fraction bits
    localparam int FRAC_BITS = 5;
    localparam int INT_BITS  = 5;
    localparam int FX_W      = INT_BITS + FRAC_BITS + 1;

    typedef logic signed [FX_W-1:0] fx_t;

    localparam fx_t FX_ONE = fx_t'(1 <<< FRAC_BITS);
    localparam fx_t FX_MAX = {1'b0, {(FX_W-1){1'b1}}};
    localparam fx_t FX_MIN = {1'b1, {(FX_W-1){1'b0}}};

    // one extra bit catches the overflow
    function automatic fx_t fx_add(input fx_t a, input fx_t b);
        logic signed [FX_W:0] s;
        s = {a[FX_W-1], a} + {b[FX_W-1], b};
        if (s[FX_W] != s[FX_W-1]) begin
            return s[FX_W] ? FX_MIN : FX_MAX;
        end
        return s[FX_W-1:0];
    endfunction

    // full product, round half up on the bit below the lsb, then saturate
    function automatic fx_t fx_mul(input fx_t a, input fx_t b);
        logic signed [2*FX_W-1:0] prod;
        logic signed [2*FX_W-1:0] q;
        prod = a * b;
        q = (prod >>> FRAC_BITS) + $signed({1'b0, prod[FRAC_BITS-1]});
        if (q > FX_MAX) begin
            return FX_MAX;
        end
        if (q < FX_MIN) begin
            return FX_MIN;
        end
        return q[FX_W-1:0];
    endfunction

    // clamp(x/4 + 1/2, 0, 1)
    function automatic fx_t fx_sigmoid_hard(input fx_t x);
        fx_t t;
        t = (x >>> 2) + (FX_ONE >>> 1);
        if (t < fx_t'(0)) begin
            return '0;
        end
        if (t > FX_ONE) begin
            return FX_ONE;
        end
        return t;
    endfunction

    // clamp(x, -1, 1)
    function automatic fx_t fx_tanh_hard(input fx_t x);
        if (x > FX_ONE) begin
            return FX_ONE;
        end
        if (x < -FX_ONE) begin
            return -FX_ONE;
        end
        return x;
    endfunction

endpackage

// File: gru_pkg.sv
package gru_pkg;

    localparam int N_IN  = 5;
    localparam int N_HID = 4;

    // selects one hidden unit
    typedef logic [$clog2(N_HID)-1:0] unit_idx_t;

    typedef fx_pkg::fx_t [N_IN-1:0]  x_vec_t;
    typedef fx_pkg::fx_t [N_HID-1:0] h_vec_t;

    // one row per hidden unit
    typedef struct packed {
        x_vec_t [N_HID-1:0] w_ir;
        x_vec_t [N_HID-1:0] w_iz;
        x_vec_t [N_HID-1:0] w_in;
        h_vec_t [N_HID-1:0] w_hr;
        h_vec_t [N_HID-1:0] w_hz;
        h_vec_t [N_HID-1:0] w_hn;
        h_vec_t             b_ir;
        h_vec_t             b_iz;
        h_vec_t             b_in;
        h_vec_t             b_hr;
        h_vec_t             b_hz;
        h_vec_t             b_hn;
    } gru_weights_t;

    // pre-activation values of the selected unit
    typedef struct packed {
        fx_pkg::fx_t r_sum;
        fx_pkg::fx_t z_sum;
        fx_pkg::fx_t n_in_sum;
        fx_pkg::fx_t n_h_sum;
    } gate_sums_t;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } seq_state_t;

endpackage

// File: gru_gate_sums.sv
`timescale 1ns/1ps

module gru_gate_sums (
    input  gru_pkg::unit_idx_t    unit,
    input  gru_pkg::x_vec_t       x,
    input  gru_pkg::h_vec_t       h_prev,
    input  gru_pkg::gru_weights_t weights,
    output gru_pkg::gate_sums_t   sums
);

    // weight rows of the selected unit
    gru_pkg::x_vec_t w_ir_row;
    gru_pkg::x_vec_t w_iz_row;
    gru_pkg::x_vec_t w_in_row;
    gru_pkg::h_vec_t w_hr_row;
    gru_pkg::h_vec_t w_hz_row;
    gru_pkg::h_vec_t w_hn_row;

    fx_pkg::fx_t r_acc;
    fx_pkg::fx_t z_acc;
    fx_pkg::fx_t n_in_acc;
    fx_pkg::fx_t n_h_acc;

    assign w_ir_row = weights.w_ir[unit];
    assign w_iz_row = weights.w_iz[unit];
    assign w_in_row = weights.w_in[unit];
    assign w_hr_row = weights.w_hr[unit];
    assign w_hz_row = weights.w_hz[unit];
    assign w_hn_row = weights.w_hn[unit];

    // saturating chains, order matters since every step saturates
    always_comb begin
        r_acc    = weights.b_ir[unit];
        z_acc    = weights.b_iz[unit];
        n_in_acc = weights.b_in[unit];

        for (int i = 0; i < gru_pkg::N_IN; i++) begin
            r_acc    = fx_pkg::fx_add(r_acc, fx_pkg::fx_mul(w_ir_row[i], x[i]));
            z_acc    = fx_pkg::fx_add(z_acc, fx_pkg::fx_mul(w_iz_row[i], x[i]));
            n_in_acc = fx_pkg::fx_add(n_in_acc, fx_pkg::fx_mul(w_in_row[i], x[i]));
        end

        // recurrent bias goes in before the h terms
        r_acc   = fx_pkg::fx_add(r_acc, weights.b_hr[unit]);
        z_acc   = fx_pkg::fx_add(z_acc, weights.b_hz[unit]);
        n_h_acc = weights.b_hn[unit];

        for (int j = 0; j < gru_pkg::N_HID; j++) begin
            r_acc   = fx_pkg::fx_add(r_acc, fx_pkg::fx_mul(w_hr_row[j], h_prev[j]));
            z_acc   = fx_pkg::fx_add(z_acc, fx_pkg::fx_mul(w_hz_row[j], h_prev[j]));
            n_h_acc = fx_pkg::fx_add(n_h_acc, fx_pkg::fx_mul(w_hn_row[j], h_prev[j]));
        end
    end

    assign sums.r_sum    = r_acc;
    assign sums.z_sum    = z_acc;
    assign sums.n_in_sum = n_in_acc;
    // still ungated, unit_update applies r
    assign sums.n_h_sum  = n_h_acc;

endmodule

// File: gru_unit_update.sv
`timescale 1ns/1ps

module gru_unit_update (
    input  gru_pkg::gate_sums_t sums,
    input  fx_pkg::fx_t         h_prev_u,
    output fx_pkg::fx_t         h_new
);

    fx_pkg::fx_t r;
    fx_pkg::fx_t z;
    fx_pkg::fx_t gated_h;
    fx_pkg::fx_t n_pre;
    fx_pkg::fx_t n;
    fx_pkg::fx_t one_minus_z;
    fx_pkg::fx_t cand_part;
    fx_pkg::fx_t keep_part;

    always_comb begin
        r = fx_pkg::fx_sigmoid_hard(sums.r_sum);
        z = fx_pkg::fx_sigmoid_hard(sums.z_sum);

        // reset gate scales only the recurrent candidate term
        gated_h = fx_pkg::fx_mul(r, sums.n_h_sum);
        n_pre   = fx_pkg::fx_add(sums.n_in_sum, gated_h);
        n       = fx_pkg::fx_tanh_hard(n_pre);

        // blend of candidate and previous state
        one_minus_z = fx_pkg::fx_add(fx_pkg::FX_ONE, -z);
        cand_part   = fx_pkg::fx_mul(one_minus_z, n);
        keep_part   = fx_pkg::fx_mul(z, h_prev_u);
    end

    assign h_new = fx_pkg::fx_add(cand_part, keep_part);

    // gate values must be usable as blend weights
    gate_range_chk : assert final (
        $isunknown(sums) ||
        (r >= fx_pkg::fx_t'(0) && r <= fx_pkg::FX_ONE &&
         z >= fx_pkg::fx_t'(0) && z <= fx_pkg::FX_ONE)
    ) else $error("gate out of range r=%h z=%h", r, z);

endmodule

// File: gru_sequencer.sv
`timescale 1ns/1ps

module gru_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    output logic               ack,
    input  fx_pkg::fx_t        h_new,
    output gru_pkg::unit_idx_t unit,
    output gru_pkg::h_vec_t    y
);

    localparam gru_pkg::unit_idx_t LAST_UNIT = gru_pkg::unit_idx_t'(gru_pkg::N_HID - 1);

    gru_pkg::seq_state_t state;

    // four-phase handshake around one sweep over the hidden units
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= gru_pkg::IDLE;
            unit  <= '0;
            ack   <= 1'b0;
        end else begin
            case (state)
                gru_pkg::IDLE: begin
                    unit <= '0;
                    if (req) begin
                        state <= gru_pkg::CALC;
                    end
                end
                gru_pkg::CALC: begin
                    // wraps back to 0 after the last unit
                    unit <= unit + 1'b1;
                    if (unit == LAST_UNIT) begin
                        state <= gru_pkg::DONE;
                        ack   <= 1'b1;
                    end
                end
                gru_pkg::DONE: begin
                    // hold until the host drops req
                    if (!req) begin
                        state <= gru_pkg::IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= gru_pkg::IDLE;
                    unit  <= '0;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // one unit result per CALC cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y <= '0;
        end else if (state == gru_pkg::CALC) begin
            y[unit] <= h_new;
        end
    end

    ack_only_in_done : assert property (
        @(posedge clk) disable iff (reset)
        (state == gru_pkg::IDLE || state == gru_pkg::CALC) |-> !ack
    ) else $error("ack high outside DONE");

    calc_starts_at_unit0 : assert property (
        @(posedge clk) disable iff (reset)
        $rose(state == gru_pkg::CALC) |-> (unit == '0)
    ) else $error("CALC entered with unit %0d", unit);

endmodule

// File: gru_top.sv
`timescale 1ns/1ps

module gru_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  gru_pkg::x_vec_t       x,
    input  gru_pkg::h_vec_t       h_prev,
    input  gru_pkg::gru_weights_t weights,
    output gru_pkg::h_vec_t       y
);

    gru_pkg::unit_idx_t  unit;
    gru_pkg::gate_sums_t sums;
    fx_pkg::fx_t         h_prev_u;
    fx_pkg::fx_t         h_new;

    // previous state of the unit being computed
    assign h_prev_u = h_prev[unit];

    gru_sequencer gru_sequencer_i (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ack   (ack),
        .h_new (h_new),
        .unit  (unit),
        .y     (y)
    );

    gru_gate_sums gru_gate_sums_i (
        .unit    (unit),
        .x       (x),
        .h_prev  (h_prev),
        .weights (weights),
        .sums    (sums)
    );

    gru_unit_update gru_unit_update_i (
        .sums     (sums),
        .h_prev_u (h_prev_u),
        .h_new    (h_new)
    );

endmodule

// File: tb_gru_ref.svh
`ifndef TB_GRU_REF_SVH
`define TB_GRU_REF_SVH

// integer model of the 11-bit word, values held as plain int
localparam int ONE_VAL  = 1 << fx_pkg::FRAC_BITS;
localparam int WORD_MAX = (1 << (fx_pkg::FX_W - 1)) - 1;
localparam int WORD_MIN = -(1 << (fx_pkg::FX_W - 1));

function automatic int word_value(input fx_pkg::fx_t v);
    return int'(v);
endfunction

function automatic int clamp_range(input int v, input int lo, input int hi);
    if (v < lo) begin
        return lo;
    end
    if (v > hi) begin
        return hi;
    end
    return v;
endfunction

function automatic int sat_sum(input int a, input int b);
    return clamp_range(a + b, WORD_MIN, WORD_MAX);
endfunction

// half an lsb added before the fraction bits are dropped
function automatic int round_product(input int a, input int b);
    int p;
    p = a * b;
    return clamp_range((p + ONE_VAL / 2) >>> fx_pkg::FRAC_BITS, WORD_MIN, WORD_MAX);
endfunction

function automatic int hard_sigmoid(input int v);
    return clamp_range((v >>> 2) + ONE_VAL / 2, 0, ONE_VAL);
endfunction

function automatic int hard_tanh(input int v);
    return clamp_range(v, -ONE_VAL, ONE_VAL);
endfunction

function automatic gru_pkg::h_vec_t gru_ref_step(
    input gru_pkg::x_vec_t       x_in,
    input gru_pkg::h_vec_t       h_in,
    input gru_pkg::gru_weights_t w
);
    gru_pkg::h_vec_t result;
    int r_acc;
    int z_acc;
    int nx_acc;
    int nh_acc;
    int r_gate;
    int z_gate;
    int cand;
    int blend;
    for (int u = 0; u < gru_pkg::N_HID; u++) begin
        r_acc  = word_value(w.b_ir[u]);
        z_acc  = word_value(w.b_iz[u]);
        nx_acc = word_value(w.b_in[u]);
        for (int i = 0; i < gru_pkg::N_IN; i++) begin
            r_acc  = sat_sum(r_acc, round_product(word_value(w.w_ir[u][i]), word_value(x_in[i])));
            z_acc  = sat_sum(z_acc, round_product(word_value(w.w_iz[u][i]), word_value(x_in[i])));
            nx_acc = sat_sum(nx_acc, round_product(word_value(w.w_in[u][i]), word_value(x_in[i])));
        end
        r_acc  = sat_sum(r_acc, word_value(w.b_hr[u]));
        z_acc  = sat_sum(z_acc, word_value(w.b_hz[u]));
        nh_acc = word_value(w.b_hn[u]);
        for (int j = 0; j < gru_pkg::N_HID; j++) begin
            r_acc  = sat_sum(r_acc, round_product(word_value(w.w_hr[u][j]), word_value(h_in[j])));
            z_acc  = sat_sum(z_acc, round_product(word_value(w.w_hz[u][j]), word_value(h_in[j])));
            nh_acc = sat_sum(nh_acc, round_product(word_value(w.w_hn[u][j]), word_value(h_in[j])));
        end
        r_gate = hard_sigmoid(r_acc);
        z_gate = hard_sigmoid(z_acc);
        // reset gate scales the recurrent candidate term only
        cand   = hard_tanh(sat_sum(nx_acc, round_product(r_gate, nh_acc)));
        blend  = sat_sum(round_product(sat_sum(ONE_VAL, -z_gate), cand),
                         round_product(z_gate, word_value(h_in[u])));
        result[u] = fx_pkg::fx_t'(blend);
    end
    return result;
endfunction

`endif

// File: tb_gru.sv
`timescale 1ns/1ps

module tb_gru;

    localparam int RANDOM_STEPS = 30;
    localparam int LARGE_STEPS  = 3;
    localparam int HOLD_STEPS   = 6;
    // about 41 steps of at most 13 cycles each, with ample margin
    localparam int CYCLE_LIMIT  = 2000;
    localparam int SMALL_MAG    = 2 * (1 << fx_pkg::FRAC_BITS);
    localparam int LARGE_MAG    = 1000;
    localparam int N_WORDS      = $bits(gru_pkg::gru_weights_t) / fx_pkg::FX_W;

    logic                  clk;
    logic                  reset;
    logic                  req;
    logic                  ack;
    gru_pkg::x_vec_t       x;
    gru_pkg::h_vec_t       h_prev;
    gru_pkg::gru_weights_t weights;
    gru_pkg::h_vec_t       y;

    gru_pkg::h_vec_t exp_y;
    logic            ack_last;
    logic            req_last;
    int              steps_done;
    int              checks_done;
    int              cycle_count;

    `include "tb_gru_ref.svh"

    gru_top gru_top_i (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .ack     (ack),
        .x       (x),
        .h_prev  (h_prev),
        .weights (weights),
        .y       (y)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles without finishing the test sequence", cycle_count);
            abort_run();
        end
    end

    // outputs sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin
        if (reset) begin
            ack_last = 1'b0;
            req_last = 1'b0;
        end else begin
            if (ack && !ack_last) begin
                assert (req_last) else begin
                    $display("handshake error: ack rose while req was low");
                    abort_run();
                end
                for (int i = 0; i < gru_pkg::N_HID; i++) begin
                    assert (y[i] == exp_y[i]) else begin
                        $display("ERR y[%0d] exp=%h got=%h", i, exp_y[i], y[i]);
                        abort_run();
                    end
                end
                checks_done++;
            end else if (ack && ack_last) begin
                // y frozen while the host holds req
                for (int i = 0; i < gru_pkg::N_HID; i++) begin
                    assert (y[i] == exp_y[i]) else begin
                        $display("ERR y[%0d] exp=%h got=%h", i, exp_y[i], y[i]);
                        abort_run();
                    end
                end
            end else if (!ack && ack_last) begin
                assert (!req_last) else begin
                    $display("handshake error: ack fell while req was still high");
                    abort_run();
                end
            end
            ack_last = ack;
            req_last = req;
        end
    end

    function automatic fx_pkg::fx_t rand_word(input int mag);
        int v;
        v = int'($urandom_range(2 * mag)) - mag;
        return fx_pkg::fx_t'(v);
    endfunction

    task automatic load_random_inputs(input int mag);
        for (int k = 0; k < N_WORDS; k++) begin
            weights[k*fx_pkg::FX_W +: fx_pkg::FX_W] = rand_word(mag);
        end
        for (int i = 0; i < gru_pkg::N_IN; i++) begin
            x[i] = rand_word(mag);
        end
    endtask

    task automatic load_random_state(input int mag);
        for (int j = 0; j < gru_pkg::N_HID; j++) begin
            h_prev[j] = rand_word(mag);
        end
    endtask

    // one four-phase step, entered and left 2 ns after a rising edge
    task automatic run_step(input int extra_hold);
        exp_y = gru_ref_step(x, h_prev, weights);
        steps_done++;
        req = 1'b1;
        while (!ack) begin
            @(posedge clk);
            #2;
        end
        repeat (extra_hold) begin
            @(posedge clk);
            #2;
        end
        req = 1'b0;
        while (ack) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        x           = '0;
        h_prev      = '0;
        weights     = '0;
        exp_y       = '0;
        ack_last    = 1'b0;
        req_last    = 1'b0;
        steps_done  = 0;
        checks_done = 0;
        cycle_count = 0;
        void'($urandom(65));

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #2;
        end

        assert (ack == 1'b0) else begin
            $display("ERR ack exp=0 got=%h", ack);
            abort_run();
        end
        for (int i = 0; i < gru_pkg::N_HID; i++) begin
            assert (y[i] == '0) else begin
                $display("ERR y[%0d] exp=%h got=%h", i, fx_pkg::fx_t'(0), y[i]);
                abort_run();
            end
        end

        // zero weights give r = z = 0.5 and n = 0
        load_random_inputs(SMALL_MAG);
        weights = '0;
        load_random_state(SMALL_MAG);
        run_step(0);
        for (int i = 0; i < gru_pkg::N_HID; i++) begin
            assert (word_value(y[i]) == round_product(ONE_VAL / 2, word_value(h_prev[i])))
            else begin
                $display("ERR y[%0d] exp=%h got=%h", i,
                         fx_pkg::fx_t'(round_product(ONE_VAL / 2, word_value(h_prev[i]))), y[i]);
                abort_run();
            end
        end

        // recurrent run, y fed back as the next state
        load_random_state(SMALL_MAG);
        for (int n = 0; n < RANDOM_STEPS; n++) begin
            load_random_inputs(SMALL_MAG);
            run_step(0);
            h_prev = y;
        end

        // wide values push sums and products into saturation
        for (int n = 0; n < LARGE_STEPS; n++) begin
            load_random_inputs(LARGE_MAG);
            load_random_state(LARGE_MAG);
            run_step(0);
        end
        for (int k = 0; k < N_WORDS; k++) begin
            weights[k*fx_pkg::FX_W +: fx_pkg::FX_W] = fx_pkg::FX_MAX;
        end
        for (int i = 0; i < gru_pkg::N_IN; i++) begin
            x[i] = fx_pkg::FX_MAX;
        end
        for (int j = 0; j < gru_pkg::N_HID; j++) begin
            h_prev[j] = fx_pkg::FX_MIN;
        end
        run_step(0);

        // host keeps req high for a while after ack
        load_random_state(SMALL_MAG);
        for (int n = 0; n < HOLD_STEPS; n++) begin
            load_random_inputs(SMALL_MAG);
            run_step(int'($urandom_range(5)));
            h_prev = y;
        end

        if (checks_done == steps_done) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d steps produced a checked result", checks_done, steps_done);
            abort_run();
        end
    end

endmodule

// File: flist.f
+incdir+.
fx_pkg.sv
gru_pkg.sv
gru_gate_sums.sv
gru_unit_update.sv
gru_sequencer.sv
gru_top.sv
tb_gru.sv
